/* Makefile */
# Verilator build and run of the multiply/divide testbench
TOP := tbMultDiv

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

obj_dir/V$(TOP): multDiv.f *.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f multDiv.f

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir

/* cycleCounter.sv */
/*
 * execute step counter
 * runs stepCount steps after each start strobe and flags the last one
 */
`timescale 1ns/1ps
`default_nettype none

module cycleCounter import mdTimingPkg::*; (
	input  wire logic clock,
	input  wire logic arstN,
	input  wire logic startStrobe,
	output logic      step,
	output logic      lastStep
);

	logic                  running;
	logic [countWidth-1:0] count;

	// the strobe edge itself is step one, so the count is loaded with 1
	// a new strobe restarts the count even in the middle of a run
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			running <= 1'b0;
			count <= '0;
		end else if (startStrobe) begin
			running <= 1'b1;
			count <= countWidth'(1);
		end else if (lastStep) begin
			running <= 1'b0;
			count <= '0;
		end else if (running) begin
			count <= count + 1'b1;
		end
	end

	// strobe cycle counts as a step so execute starts on the edge after the latch
	assign step = startStrobe | running;
	// high in the cycle ending at the 32nd step edge
	assign lastStep = running & (count == countWidth'(stepCount - 1));

endmodule

`default_nettype wire

/* mdDecode.sv */
/*
 * start decode and operand latch
 * picks the opcode, stores operand magnitudes and the sign of the result
 */
`timescale 1ns/1ps
`default_nettype none

module mdDecode import mdOpsPkg::*; (
	input  wire logic                 clock,
	input  wire logic                 arstN,
	input  wire logic                 ctrlMult,
	input  wire logic                 ctrlDiv,
	input  wire logic [dataWidth-1:0] operandA,
	input  wire logic [dataWidth-1:0] operandB,
	output mdOpT                      op,
	output logic [dataWidth-1:0]      magA,
	output logic [dataWidth-1:0]      magB,
	output logic                      negResult,
	output logic                      divZero,
	output logic                      startStrobe
);

	logic start;
	logic isDiv;

	assign start = ctrlMult | ctrlDiv;
	// multiply has priority when both requests arrive together
	assign isDiv = ctrlDiv & ~ctrlMult;

	// opcode and strobe are control state
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			op <= opNone;
			startStrobe <= 1'b0;
		end else begin
			startStrobe <= start;
			if (start) begin
				op <= isDiv ? opDiv : opMult;
			end
		end
	end

	// operand payload, held until the next start
	always_ff @(posedge clock) begin
		if (start) begin
			// two's complement magnitude, the minimum value maps to 2^31 unsigned
			magA <= operandA[dataWidth-1] ? -operandA : operandA;
			magB <= operandB[dataWidth-1] ? -operandB : operandB;
			// same sign rule for product and quotient
			negResult <= operandA[dataWidth-1] ^ operandB[dataWidth-1];
			divZero <= isDiv & (operandB == '0);
		end
	end

endmodule

`default_nettype wire

/* mdExecute.sv */
/*
 * unsigned iterative datapath
 * shift-add multiplier and restoring divider sharing one register pair
 */
`timescale 1ns/1ps
`default_nettype none

module mdExecute import mdOpsPkg::*; (
	input  wire logic                 clock,
	input  wire logic                 arstN,
	input  wire logic                 startStrobe,
	input  mdOpT                      op,
	input  wire logic [dataWidth-1:0] magA,
	input  wire logic [dataWidth-1:0] magB,
	input  wire logic                 step,
	input  wire logic                 lastStep,
	output logic [dataWidth-1:0]      rawLow,
	output logic [dataWidth-1:0]      rawHigh,
	output logic                      rawDone
);

	// multiply: accHi is the running upper product, accLo the multiplier
	// shifting out while product bits shift in
	// divide: accHi is the partial remainder, accLo the dividend shifting
	// out while quotient bits shift in
	logic [dataWidth-1:0] accHi;
	logic [dataWidth-1:0] accLo;

	logic [dataWidth-1:0] curHi;
	logic [dataWidth-1:0] curLo;
	logic [dataWidth-1:0] nextHi;
	logic [dataWidth-1:0] nextLo;

	// one extra bit for the carry out of the add
	logic [dataWidth:0]   addSum;
	// remainder after the left shift, may be one bit wider than a word
	logic [dataWidth:0]   remShift;
	// top bit is the borrow of the trial subtract
	logic [dataWidth+1:0] trialDiff;
	logic                 trialOk;

	// on the strobe edge the first step works on the freshly loaded operands
	always_comb begin
		if (startStrobe) begin
			curHi = '0;
			curLo = (op == opDiv) ? magA : magB;
		end else begin
			curHi = accHi;
			curLo = accLo;
		end
	end

	// multiply step
	// add the multiplicand when the multiplier lsb is set
	assign addSum = {1'b0, curHi} + (curLo[0] ? {1'b0, magA} : {(dataWidth + 1){1'b0}});

	// divide step
	// bring the next dividend bit into the remainder and try the divisor
	assign remShift = {curHi, curLo[dataWidth-1]};
	assign trialDiff = {1'b0, remShift} - {2'b00, magB};
	assign trialOk = ~trialDiff[dataWidth+1];

	always_comb begin
		if (op == opDiv) begin
			// restore on borrow, otherwise keep the difference
			// the kept remainder is below the divisor so it fits one word
			nextHi = trialOk ? trialDiff[dataWidth-1:0] : remShift[dataWidth-1:0];
			nextLo = {curLo[dataWidth-2:0], trialOk};
		end else begin
			// shift the whole 65-bit sum right by one
			nextHi = addSum[dataWidth:1];
			nextLo = {addSum[0], curLo[dataWidth-1:1]};
		end
	end

	always_ff @(posedge clock) begin
		if (step) begin
			accHi <= nextHi;
			accLo <= nextLo;
		end
	end

	// a restart landing on the last step cancels the stale done
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			rawDone <= 1'b0;
		end else begin
			rawDone <= lastStep & ~startStrobe;
		end
	end

	// low word is the product low half or the quotient
	assign rawLow = accLo;
	// high word is the product high half, the remainder is not used
	assign rawHigh = accHi;

endmodule

`default_nettype wire

/* mdOpsPkg.sv */
/*
 * operation definitions for the iterative multiply/divide unit
 * data width and the opcode encoding shared by decode, execute and result
 */
`default_nettype none

package mdOpsPkg;

	// operand and result width, the unit exists only at 32 bits
	localparam int dataWidth = 32;

	// opcode latched at a start
	// opNone only appears out of reset, before the first start
	typedef enum logic [1:0] {
		opNone = 2'd0,
		opMult = 2'd1,
		opDiv  = 2'd2
	} mdOpT;

endpackage

`default_nettype wire

/* mdResult.sv */
/*
 * result stage
 * restores the sign, flags overflow or divide by zero, holds the result
 */
`timescale 1ns/1ps
`default_nettype none

module mdResult import mdOpsPkg::*, mdTimingPkg::*; (
	input  wire logic                 clock,
	input  wire logic                 arstN,
	input  wire logic                 startStrobe,
	input  wire logic                 rawDone,
	input  mdOpT                      op,
	input  wire logic                 negResult,
	input  wire logic                 divZero,
	input  wire logic [dataWidth-1:0] rawLow,
	input  wire logic [dataWidth-1:0] rawHigh,
	output logic [dataWidth-1:0]      result,
	output logic                      exception,
	output logic                      resultReady
);

	resStateT state;

	logic [2*dataWidth-1:0] rawProd;
	logic [2*dataWidth-1:0] signedProd;
	logic [dataWidth-1:0]   signedQuo;
	logic                   multOverflow;
	logic                   divOverflow;

	assign rawProd = {rawHigh, rawLow};
	assign signedProd = negResult ? -rawProd : rawProd;
	assign signedQuo = negResult ? -rawLow : rawLow;

	// product does not fit when the upper half is not a sign extension
	assign multOverflow = signedProd[2*dataWidth-1:dataWidth] != {dataWidth{signedProd[dataWidth-1]}};
	// only min / -1 gives a positive quotient of 2^31
	assign divOverflow = ~negResult & rawLow[dataWidth-1];

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= resIdle;
			result <= '0;
			exception <= 1'b0;
		end else if (startStrobe) begin
			// also drops resultReady of the previous operation
			state <= resBusy;
		end else if (state == resBusy && rawDone) begin
			state <= resDone;
			case (op)
				opMult: begin
					result <= signedProd[dataWidth-1:0];
					exception <= multOverflow;
				end
				opDiv: begin
					// zero divisor forces a zero result
					result <= divZero ? '0 : signedQuo;
					exception <= divZero | divOverflow;
				end
				default: begin
					result <= '0;
					exception <= 1'b0;
				end
			endcase
		end
	end

	assign resultReady = (state == resDone);

endmodule

`default_nettype wire

/* mdTimingPkg.sv */
/*
 * sequencing definitions for the multiply/divide unit
 * step count, counter width, overall latency and the result stage states
 */
`default_nettype none

package mdTimingPkg;

	// one shift-add or shift-subtract per clock
	localparam int stepCount = 32;
	localparam int countWidth = 6;
	// start edge to resultReady high, in clock edges
	localparam int latency = 33;

	typedef enum logic [1:0] {
		resIdle = 2'd0,
		resBusy = 2'd1,
		resDone = 2'd2
	} resStateT;

endpackage

`default_nettype wire

/* multDiv.f */
mdOpsPkg.sv
mdTimingPkg.sv
cycleCounter.sv
mdDecode.sv
mdExecute.sv
mdResult.sv
multDiv.sv
tbClockGen.sv
multDiv_assertions.sv
tbMultDiv.sv

/* multDiv.sv */
/*
 * iterative signed multiply/divide unit
 * start pulse in, 32 execute steps, result held with resultReady
 */
`timescale 1ns/1ps
`default_nettype none

module multDiv import mdOpsPkg::*; (
	input  wire logic                 clock,
	input  wire logic                 arstN,
	input  wire logic                 ctrlMult,
	input  wire logic                 ctrlDiv,
	input  wire logic [dataWidth-1:0] operandA,
	input  wire logic [dataWidth-1:0] operandB,
	output logic [dataWidth-1:0]      result,
	output logic                      exception,
	output logic                      resultReady
);

	mdOpT                 op;
	logic [dataWidth-1:0] magA;
	logic [dataWidth-1:0] magB;
	logic                 negResult;
	logic                 divZero;
	logic                 startStrobe;
	logic                 step;
	logic                 lastStep;
	logic [dataWidth-1:0] rawLow;
	logic [dataWidth-1:0] rawHigh;
	logic                 rawDone;

	// operands latched at the start edge, strobe one edge later
	mdDecode u_decode (
		.clock(clock), .arstN(arstN), .ctrlMult(ctrlMult), .ctrlDiv(ctrlDiv),
		.operandA(operandA), .operandB(operandB), .op(op), .magA(magA), .magB(magB),
		.negResult(negResult), .divZero(divZero), .startStrobe(startStrobe)
	);

	cycleCounter u_counter (
		.clock(clock), .arstN(arstN), .startStrobe(startStrobe),
		.step(step), .lastStep(lastStep)
	);

	// steps on edges one through 32 after the start edge
	mdExecute u_execute (
		.clock(clock), .arstN(arstN), .startStrobe(startStrobe), .op(op),
		.magA(magA), .magB(magB), .step(step), .lastStep(lastStep),
		.rawLow(rawLow), .rawHigh(rawHigh), .rawDone(rawDone)
	);

	// loads on edge 33, ready held until the next strobe
	mdResult u_result (
		.clock(clock), .arstN(arstN), .startStrobe(startStrobe), .rawDone(rawDone),
		.op(op), .negResult(negResult), .divZero(divZero), .rawLow(rawLow),
		.rawHigh(rawHigh), .result(result), .exception(exception),
		.resultReady(resultReady)
	);

endmodule

`default_nettype wire

/* multDiv_assertions.sv */
/*
 * concurrent timing checks for the multiply/divide unit
 * latency from start to resultReady, drop after a start, stable result
 */
`timescale 1ns/1ps
`default_nettype none

module multDiv_assertions import mdOpsPkg::*, mdTimingPkg::*; (
	input wire logic                 clock,
	input wire logic                 arstN,
	input wire logic                 ctrlMult,
	input wire logic                 ctrlDiv,
	input wire logic [dataWidth-1:0] result,
	input wire logic                 exception,
	input wire logic                 resultReady
);

	logic       start;
	logic       startSeen;
	logic       tracking;
	logic [7:0] age;
	// number of failed assertions so far
	int         failCount;

	assign start = ctrlMult | ctrlDiv;

	// age counts edges since the latest start, stops just past the latency
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			startSeen <= 1'b0;
			tracking <= 1'b0;
			age <= '0;
		end else begin
			startSeen <= start;
			if (start) begin
				tracking <= 1'b1;
				age <= '0;
			end else if (tracking && age <= 8'(latency)) begin
				age <= age + 8'd1;
			end
		end
	end

	// low from the edge after the start up to the latency edge
	assert property (@(posedge clock) disable iff (!arstN)
		(tracking && age >= 8'd1 && age < 8'(latency)) |-> !resultReady)
		else begin
			$error("resultReady high before the latency elapsed");
			failCount++;
		end

	// high right after the latency edge
	assert property (@(posedge clock) disable iff (!arstN)
		(tracking && age == 8'(latency)) |-> resultReady)
		else begin
			$error("resultReady did not rise at the latency edge");
			failCount++;
		end

	// previous result is withdrawn on the edge after a start
	assert property (@(posedge clock) disable iff (!arstN)
		startSeen |=> !resultReady)
		else begin
			$error("resultReady still high after a start");
			failCount++;
		end

	assert property (@(posedge clock) disable iff (!arstN)
		(resultReady && $past(resultReady)) |-> ($stable(result) && $stable(exception)))
		else begin
			$error("result changed while resultReady was high");
			failCount++;
		end

endmodule

bind multDiv multDiv_assertions u_assertions (
	.clock(clock), .arstN(arstN), .ctrlMult(ctrlMult), .ctrlDiv(ctrlDiv),
	.result(result), .exception(exception), .resultReady(resultReady)
);

`default_nettype wire

/* tbClockGen.sv */
/*
 * testbench clock and reset
 * 10 ns clock, active low reset held for the first 10 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
	output logic clock,
	output logic arstN
);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// release just after an edge, like the other stimulus
	initial begin
		arstN = 1'b0;
		repeat (10) @(posedge clock);
		#1;
		arstN = 1'b1;
	end

endmodule

`default_nettype wire

/* tbMultDiv.sv */
/*
 * testbench for the multiply/divide unit
 * directed and LFSR driven signed operations against a 64-bit reference
 */
`timescale 1ns/1ps
`default_nettype none

module tbMultDiv import mdOpsPkg::*, mdTimingPkg::*; ();

	logic                 clock;
	logic                 arstN;
	logic                 ctrlMult;
	logic                 ctrlDiv;
	logic [dataWidth-1:0] operandA;
	logic [dataWidth-1:0] operandB;
	logic [dataWidth-1:0] result;
	logic                 exception;
	logic                 resultReady;

	logic [31:0] lfsrState;
	logic [32:0] expQ[$];
	logic [63:0] argQ[$];
	int          errors;
	int          checks;
	int          timeouts;
	int          issued;
	int          doneCount;

	tbClockGen u_clockGen (.clock(clock), .arstN(arstN));

	multDiv u_multDiv (
		.clock(clock), .arstN(arstN), .ctrlMult(ctrlMult), .ctrlDiv(ctrlDiv),
		.operandA(operandA), .operandB(operandB), .result(result),
		.exception(exception), .resultReady(resultReady)
	);

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one LFSR step per bit taken
	task automatic randomBits(input int n, output logic [31:0] w);
		w = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			w = {w[30:0], lfsrState[0]};
		end
	endtask

	// expected {exception, result} from plain 64-bit signed arithmetic
	function automatic logic [32:0] refModel(input logic isDiv, input logic [31:0] a,
			input logic [31:0] b);
		logic signed [63:0] wideA;
		logic signed [63:0] wideB;
		logic signed [63:0] full;
		wideA = {{32{a[31]}}, a};
		wideB = {{32{b[31]}}, b};
		if (isDiv && b == 32'd0) begin
			return {1'b1, 32'd0};
		end
		full = isDiv ? wideA / wideB : wideA * wideB;
		// does not fit when the upper half is not a sign extension
		return {full != {{32{full[31]}}, full[31:0]}, full[31:0]};
	endfunction

	// one-cycle start pulse
	task automatic startOp(input logic mult, input logic div, input logic [31:0] a,
			input logic [31:0] b);
		@(posedge clock);
		#1;
		ctrlMult = mult;
		ctrlDiv = div;
		operandA = a;
		operandB = b;
		@(posedge clock);
		#1;
		ctrlMult = 1'b0;
		ctrlDiv = 1'b0;
	endtask

	// start, hand the expected value to the compare process, wait for it
	task automatic runOp(input logic mult, input logic div, input logic [31:0] a,
			input logic [31:0] b);
		int waitCount;
		startOp(mult, div, a, b);
		// old ready is gone after this edge
		@(posedge clock);
		#1;
		expQ.push_back(refModel(div & ~mult, a, b));
		argQ.push_back({a, b});
		issued++;
		waitCount = 0;
		while (doneCount != issued && waitCount < 50) begin
			@(posedge clock);
			waitCount++;
		end
		if (doneCount != issued) begin
			timeouts++;
			$display("timeout: no compare result for a=%h b=%h", a, b);
		end
	endtask

	// outputs are sampled on the falling edge where they are settled
	initial begin : compare
		logic [32:0] expected;
		logic [63:0] args;
		int          waitCycles;
		forever begin
			@(negedge clock);
			if (expQ.size() != 0) begin
				expected = expQ.pop_front();
				args = argQ.pop_front();
				waitCycles = 0;
				while (!resultReady && waitCycles < 40) begin
					@(negedge clock);
					waitCycles++;
				end
				if (!resultReady) begin
					timeouts++;
					$display("timeout: resultReady stayed low for 40 cycles, a=%h b=%h",
						args[63:32], args[31:0]);
				end else begin
					checks++;
					// first sample is one edge after the start edge
					if (waitCycles != latency - 1) begin
						errors++;
						$display("error at %0t: ready after %0d cycles, a=%h b=%h", $time,
							waitCycles + 1, args[63:32], args[31:0]);
					end
					if (result !== expected[31:0] || exception !== expected[32]) begin
						errors++;
						$display("error at %0t: a=%h b=%h gave %h exc %b, expected %h exc %b",
							$time, args[63:32], args[31:0], result, exception,
							expected[31:0], expected[32]);
					end
				end
				doneCount++;
			end
		end
	end

	initial begin : stimulus
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sh;
		int          waitCount;
		ctrlMult = 1'b0;
		ctrlDiv = 1'b0;
		operandA = '0;
		operandB = '0;
		lfsrState = 32'hda4c_83d7;
		waitCount = 0;
		while (!arstN && waitCount < 20) begin
			@(posedge clock);
			waitCount++;
		end
		if (!arstN) begin
			timeouts++;
			$display("reset was never released");
		end
		@(negedge clock);
		checks++;
		if (resultReady !== 1'b0 || exception !== 1'b0 || result !== '0) begin
			errors++;
			$display("error at %0t: outputs not cleared by reset", $time);
		end
		// multiply corners, then random operands of random magnitude
		runOp(1'b1, 1'b0, 32'h8000_0000, 32'hffff_ffff);
		runOp(1'b1, 1'b0, 32'h0000_0000, 32'h1234_5678);
		runOp(1'b1, 1'b0, 32'h7fff_ffff, 32'h7fff_ffff);
		runOp(1'b1, 1'b0, 32'h7fff_ffff, 32'h0000_0001);
		runOp(1'b1, 1'b0, 32'h8000_0000, 32'h0000_0001);
		for (int i = 5; i < 200; i++) begin
			randomBits(32, a);
			randomBits(5, sh);
			a = $signed(a) >>> sh;
			randomBits(32, b);
			randomBits(5, sh);
			b = $signed(b) >>> sh;
			runOp(1'b1, 1'b0, a, b);
		end
		// divide corners, min / -1 overflows
		runOp(1'b0, 1'b1, 32'h8000_0000, 32'hffff_ffff);
		runOp(1'b0, 1'b1, 32'h8000_0000, 32'h0000_0001);
		runOp(1'b0, 1'b1, 32'hffff_fff9, 32'h0000_0002);
		runOp(1'b0, 1'b1, 32'h0000_0007, 32'hffff_fffe);
		runOp(1'b0, 1'b1, 32'h0000_0003, 32'h0000_000a);
		runOp(1'b0, 1'b1, 32'hffff_fffd, 32'hffff_fff6);
		runOp(1'b0, 1'b1, 32'h0000_0064, 32'hffff_fff9);
		for (int i = 7; i < 200; i++) begin
			randomBits(32, a);
			randomBits(32, b);
			randomBits(5, sh);
			b = $signed(b) >>> sh;
			runOp(1'b0, 1'b1, a, b);
		end
		// zero divisor
		runOp(1'b0, 1'b1, 32'h0000_007b, 32'h0000_0000);
		runOp(1'b0, 1'b1, 32'h8000_0000, 32'h0000_0000);
		runOp(1'b0, 1'b1, 32'h0000_0000, 32'h0000_0000);
		// restart partway, only the divide may come out
		startOp(1'b1, 1'b0, 32'h7fff_ffff, 32'h0001_2345);
		repeat (10) @(posedge clock);
		runOp(1'b0, 1'b1, 32'hffff_fc18, 32'h0000_0007);
		// both requests together, multiply wins
		runOp(1'b1, 1'b1, 32'h0000_0006, 32'hffff_fffd);
		$display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d", checks,
			errors, timeouts, u_multDiv.u_assertions.failCount);
		if (errors == 0 && timeouts == 0 && u_multDiv.u_assertions.failCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
